//--- Bender.yml
package:
  name: graphics_overlay

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/graphics_pkg.sv
      - verilog/frame_timer.sv
      - verilog/gfx_apb_regs.sv
      - verilog/symbol_iter.sv
      - verilog/graphics_fsm.sv
      - verilog/fill_drawer.sv
      - verilog/symbol_drawer.sv
      - verilog/pixel_port.sv
      - verilog/graphics_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/tb_graphics_top.sv

//--- sim.f
+incdir+verilog
verilog/graphics_pkg.sv
verilog/frame_timer.sv
verilog/gfx_apb_regs.sv
verilog/symbol_iter.sv
verilog/graphics_fsm.sv
verilog/fill_drawer.sv
verilog/symbol_drawer.sv
verilog/pixel_port.sv
verilog/graphics_top.sv
testbench/tb_graphics_top.sv

//--- testbench/tb_graphics_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "graphics_settings.svh"

module tb_graphics_top;

    localparam int FB_SIZE = `GFX_HOR_PIXELS * `GFX_VER_PIXELS;
    // three frames under back-pressure with their swap waits, plus ample margin.
    localparam int TIMEOUT_CYCLES = 40000;

    localparam logic [5:0] ADDR_CTRL   = 6'h00;
    localparam logic [5:0] ADDR_COLORS = 6'h04;
    localparam logic [5:0] ADDR_STATUS = 6'h08;
    localparam logic [5:0] ADDR_TEXT0  = 6'h10;

    logic                      clk;
    logic                      rst_n;
    logic                      pix_ready;
    logic                      pix_valid;
    graphics_pkg::apb_req_t    apb_req;
    graphics_pkg::apb_rsp_t    apb_rsp;
    graphics_pkg::pix_wr_t     pix;

    logic [7:0]                fb [FB_SIZE];
    logic [7:0]                exp_fb [FB_SIZE];
    int                        pix_count = 0;
    int                        cycle_count = 0;
    int                        checks = 0;
    int                        errors = 0;
    integer                    seed = 32'h36c0;

    // host view of the registers, and the frame handed to the checker.
    graphics_pkg::color_pair_t tb_colors;
    graphics_pkg::text_buf_t   tb_text;
    graphics_pkg::color_pair_t check_colors;
    graphics_pkg::text_buf_t   check_text;
    logic                      check_req;

    graphics_top UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .pix       (pix),
        .pix_valid (pix_valid),
        .pix_ready (pix_ready)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // about three quarters of the cycles accept a pixel.
    always @(posedge clk) begin
        #10;
        pix_ready = (($random(seed) & 3) != 0);
    end

    // framebuffer model.
    always @(posedge clk) begin
        if (rst_n && pix_valid && pix_ready) begin
            fb[int'(pix.y) * `GFX_HOR_PIXELS + int'(pix.x)] <= pix.color;
            pix_count <= pix_count + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout, the frames did not finish within %0d cycles", TIMEOUT_CYCLES);
            print_counts();
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic void print_counts();
        $display("checks: %0d  errors: %0d", checks, errors);
    endfunction

    // builds the expected frame and returns its pixel count.
    function automatic int build_expected_frame(input graphics_pkg::color_pair_t colors,
                                                input graphics_pkg::text_buf_t   line);
        int count;
        int x0;
        int y0;
        bit drawing;
        count   = FB_SIZE;
        y0      = `GFX_VER_PIXELS - `GFX_BASELINE_OFS;
        drawing = 1'b1;
        for (int i = 0; i < FB_SIZE; i++) begin
            exp_fb[i] = colors.bg;
        end
        for (int s = 0; s < `GFX_TEXT_DEPTH; s++) begin
            if (drawing) begin
                x0 = s * `GFX_CELL_STEP;
                for (int r = 0; r < `GFX_GLYPH_H; r++) begin
                    for (int c = 0; c < `GFX_GLYPH_W; c++) begin
                        if (line[s][(c + r) % `GFX_SYMBOL_WIDTH]) begin
                            exp_fb[(y0 + r) * `GFX_HOR_PIXELS + x0 + c] = colors.fg;
                            count++;
                        end
                    end
                end
                if (line[s] == '0) drawing = 1'b0; // the first 0 ends the line.
            end
        end
        return count;
    endfunction

    // marker pattern so unwritten pixels show up.
    task automatic fill_framebuffer();
        for (int i = 0; i < FB_SIZE; i++) begin
            fb[i] <= 8'h80 | 8'((i & 8'h7f) ^ (i >> 7));
        end
    endtask

    // compare process that runs once per open window.
    initial begin : compare_frames
        int exp_count;
        forever begin
            wait (check_req);
            do @(negedge clk); while (pix_valid); // last pixel may still be queued.
            exp_count = build_expected_frame(check_colors, check_text);
            for (int i = 0; i < FB_SIZE; i++) begin
                checks++;
                assert (fb[i] === exp_fb[i]) else begin
                    errors++;
                    $display("CHECK FAILED fb[x=%0d,y=%0d] got %h expected %h",
                             i % `GFX_HOR_PIXELS, i / `GFX_HOR_PIXELS, fb[i], exp_fb[i]);
                end
            end
            checks++;
            assert (pix_count == exp_count) else begin
                errors++;
                $display("CHECK FAILED pix_count got %h expected %h", pix_count, exp_count);
            end
            pix_count <= 0;
            fill_framebuffer();
            check_req = 1'b0;
        end
    end

    // every access completes in its second cycle.
    task automatic check_pready(input logic ready);
        checks++;
        assert (ready === 1'b1) else begin
            errors++;
            $display("CHECK FAILED pready got %h expected %h", ready, 1'b1);
        end
    endtask

    task automatic apb_write(input logic [5:0] addr, input logic [31:0] data);
        @(posedge clk);
        #10;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b1;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        @(posedge clk);
        #10;
        apb_req.penable = 1'b1;
        @(negedge clk);
        check_pready(apb_rsp.pready);
        @(posedge clk);
        #10;
        apb_req = '0;
    endtask

    task automatic apb_read(input logic [5:0] addr, output logic [31:0] data,
                            output logic slverr);
        @(posedge clk);
        #10;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
        apb_req.paddr   = addr;
        @(posedge clk);
        #10;
        apb_req.penable = 1'b1;
        @(negedge clk);
        data   = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        check_pready(apb_rsp.pready);
        @(posedge clk);
        #10;
        apb_req = '0;
    endtask

    task automatic wait_window_open();
        logic [31:0] status;
        logic        slverr;
        status = '0;
        while (!status[0]) apb_read(ADDR_STATUS, status, slverr);
    endtask

    task automatic check_status(input int exp_frames, input logic exp_window);
        logic [31:0] status;
        logic        slverr;
        apb_read(ADDR_STATUS, status, slverr);
        checks += 2;
        assert (status[15:8] == 8'(exp_frames)) else begin
            errors++;
            $display("CHECK FAILED status.frame_count got %h expected %h",
                     status[15:8], 8'(exp_frames));
        end
        assert (status[0] == exp_window) else begin
            errors++;
            $display("CHECK FAILED status.window got %h expected %h", status[0], exp_window);
        end
    endtask

    task automatic set_colors(input logic [7:0] fg, input logic [7:0] bg);
        apb_write(ADDR_COLORS, {16'h0, bg, fg});
        tb_colors.fg = fg;
        tb_colors.bg = bg;
    endtask

    task automatic write_text(input int idx, input graphics_pkg::symbol_t sym);
        apb_write(6'(ADDR_TEXT0 + 4 * idx), 32'(sym));
        tb_text[idx] = sym;
    endtask

    task automatic request_frame_check();
        check_colors = tb_colors;
        check_text   = tb_text;
        check_req    = 1'b1;
        wait (!check_req);
    endtask

    initial begin : stimulus
        logic [31:0] rdata;
        logic        slverr;
        rst_n     = 1'b0;
        pix_ready = 1'b0;
        apb_req   = '0;
        check_req = 1'b0;
        tb_colors = '0;
        tb_text   = '0;
        fill_framebuffer();
        repeat (16) @(posedge clk);
        #10;
        rst_n = 1'b1;

        // first frame with reset colors and an empty buffer.
        wait_window_open();
        request_frame_check();
        check_status(0, 1'b1);
        set_colors(8'he5, 8'h21);
        write_text(0, 7'h7f);
        write_text(1, 7'h15);
        write_text(2, 7'h00);
        write_text(3, 7'h2a);
        apb_write(ADDR_CTRL, 32'h3); // enable and done.
        check_status(1, 1'b0);

        // the window is closed so this done is ignored.
        apb_write(ADDR_CTRL, 32'h3);
        check_status(1, 1'b0);
        apb_read(6'h0c, rdata, slverr);
        checks++;
        assert (slverr === 1'b1) else begin
            errors++;
            $display("CHECK FAILED pslverr got %h expected %h", slverr, 1'b1);
        end

        // second frame stops at the 0 entry.
        wait_window_open();
        request_frame_check();
        set_colors(8'h36, 8'h4b);
        write_text(0, 7'h11);
        write_text(1, 7'h2a);
        write_text(2, 7'h55);
        write_text(3, 7'h63);
        apb_write(ADDR_CTRL, 32'h3);
        check_status(2, 1'b0);

        // third frame draws all four glyphs.
        wait_window_open();
        request_frame_check();
        apb_write(ADDR_CTRL, 32'h3);
        check_status(3, 1'b0);

        print_counts();
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/fill_drawer.sv
`timescale 1ns/100ps
`default_nettype none

`include "graphics_settings.svh"

module fill_drawer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  logic [7:0]            bg,
    output graphics_pkg::pix_wr_t pix,
    output logic                  pix_valid,
    input  logic                  pix_ready,
    output logic                  ready
);

    localparam logic [`GFX_X_W-1:0] X_LAST = `GFX_X_W'(`GFX_HOR_PIXELS - 1);
    localparam logic [`GFX_Y_W-1:0] Y_LAST = `GFX_Y_W'(`GFX_VER_PIXELS - 1);

    logic                busy;
    logic [`GFX_X_W-1:0] x;
    logic [`GFX_Y_W-1:0] y;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            x    <= '0;
            y    <= '0;
        end else if (start) begin
            busy <= 1'b1;
            x    <= '0;
            y    <= '0;
        end else if (busy && pix_ready) begin
            x <= (x == X_LAST) ? '0 : x + 1'b1;
            if (x == X_LAST) begin
                y <= y + 1'b1; // row major.
                if (y == Y_LAST) busy <= 1'b0;
            end
        end
    end

    assign pix       = '{x: x, y: y, color: bg};
    assign pix_valid = busy;
    assign ready     = !busy;

endmodule

`default_nettype wire

//--- verilog/frame_timer.sv
`timescale 1ns/100ps
`default_nettype none

`include "graphics_settings.svh"

module frame_timer (
    input  logic clk,
    input  logic rst_n,
    input  logic enable,
    output logic swap
);

    localparam int CNT_W = $clog2(`GFX_FRAME_CYCLES);
    localparam logic [CNT_W-1:0] RELOAD = CNT_W'(`GFX_FRAME_CYCLES - 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (!rst_n || !enable) begin
            count <= RELOAD; // parked while disabled.
        end else if (count == '0) begin
            count <= RELOAD;
        end else begin
            count <= count - 1'b1;
        end
    end

    assign swap = enable && (count == '0);

    // one tick per period, never back to back.
    swap_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        swap |=> !swap);

endmodule

`default_nettype wire

//--- verilog/gfx_apb_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "graphics_settings.svh"

module gfx_apb_regs (
    input  logic                     clk,
    input  logic                     rst_n,
    input  graphics_pkg::apb_req_t   apb_req,
    output graphics_pkg::apb_rsp_t   apb_rsp,
    input  logic                     logic_start,
    input  logic                     frame_done,
    output logic                     enable,
    output graphics_pkg::color_pair_t colors,
    output graphics_pkg::text_buf_t  text,
    output logic                     logic_ready
);

    localparam logic [5:0] ADDR_CTRL   = 6'h00;
    localparam logic [5:0] ADDR_COLORS = 6'h04;
    localparam logic [5:0] ADDR_STATUS = 6'h08;

    logic        access;
    logic        wr;
    logic        hit;
    logic        done_wr;
    logic        window;
    logic [7:0]  frame_cnt;
    logic [31:0] rdata;

    assign access  = apb_req.psel && apb_req.penable;
    assign wr      = access && apb_req.pwrite && hit;
    assign done_wr = wr && (apb_req.paddr == ADDR_CTRL) && apb_req.pwdata[1];

    always_comb begin
        hit   = 1'b1;
        rdata = '0;
        case (apb_req.paddr)
            ADDR_CTRL:   rdata[0] = enable;
            ADDR_COLORS: rdata[15:0] = {colors.bg, colors.fg};
            ADDR_STATUS: rdata[15:0] = {frame_cnt, 7'b0, window};
            6'h10, 6'h14, 6'h18, 6'h1c: begin
                rdata[`GFX_SYMBOL_WIDTH-1:0] = text[apb_req.paddr[3:2]];
            end
            default:     hit = 1'b0;
        endcase
    end

    always_comb begin
        apb_rsp.prdata  = rdata;
        apb_rsp.pready  = 1'b1; // no wait states.
        apb_rsp.pslverr = access && !hit;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            enable <= 1'b0;
            colors <= '0;
            text   <= '0;
        end else if (wr) begin
            case (apb_req.paddr)
                ADDR_CTRL:   enable <= apb_req.pwdata[0]; // done bit is not stored.
                ADDR_COLORS: colors <= {apb_req.pwdata[7:0], apb_req.pwdata[15:8]};
                ADDR_STATUS: ; // read only.
                default:     text[apb_req.paddr[3:2]] <= apb_req.pwdata[`GFX_SYMBOL_WIDTH-1:0];
            endcase
        end
    end

    // logic window, opened by the sequencer and closed by the host.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            window      <= 1'b0;
            logic_ready <= 1'b0;
            frame_cnt   <= '0;
        end else begin
            logic_ready <= done_wr && window;
            if (logic_start) begin
                window <= 1'b1;
            end else if (done_wr) begin
                window <= 1'b0;
            end
            if (frame_done) begin
                frame_cnt <= frame_cnt + 1'b1; // wraps at 256.
            end
        end
    end

    apb_access_after_setup: assert property (@(posedge clk) disable iff (!rst_n)
        apb_req.penable |-> apb_req.psel);

endmodule

`default_nettype wire

//--- verilog/graphics_fsm.sv
`timescale 1ns/100ps
`default_nettype none

`include "graphics_settings.svh"

module graphics_fsm (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  swap,
    input  graphics_pkg::symbol_t symbol,
    input  logic                  symbol_valid,
    input  logic                  logic_ready,
    input  logic                  fill_ready,
    input  logic                  sym_ready,
    output logic                  iter_start,
    output logic                  iter_en,
    output logic                  logic_start,
    output logic                  fill_start,
    output logic                  sym_start,
    output logic [`GFX_X_W-1:0]   sym_x
);

    graphics_pkg::gfx_state_e state;
    logic                     sym_done;

    // drawer finished with the current symbol.
    assign sym_done = sym_ready && (state == graphics_pkg::STATE_DRAW_FIRST_SYMBOL_3 ||
                                    state == graphics_pkg::STATE_WAIT_SYMBOL_DRAWER_2);

    // rewind while the fill runs, step after each drawn glyph.
    assign iter_start = (state == graphics_pkg::STATE_FILL_DRAWER_START);
    assign iter_en    = sym_done && (symbol != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= graphics_pkg::STATE_FILL_DRAWER_START;
            logic_start <= 1'b0;
            fill_start  <= 1'b0;
            sym_start   <= 1'b0;
            sym_x       <= '0;
        end else begin
            fill_start  <= 1'b0;
            sym_start   <= 1'b0;
            logic_start <= 1'b0;
            case (state)
                graphics_pkg::STATE_WAIT_SWAP: begin
                    if (swap) state <= graphics_pkg::STATE_FILL_DRAWER_START;
                end
                graphics_pkg::STATE_FILL_DRAWER_START: begin
                    fill_start <= 1'b1;
                    state      <= graphics_pkg::STATE_WAIT_FILL_DRAWER_1;
                end
                graphics_pkg::STATE_WAIT_FILL_DRAWER_1: begin
                    state <= graphics_pkg::STATE_WAIT_FILL_DRAWER_2; // ready not valid yet.
                end
                graphics_pkg::STATE_WAIT_FILL_DRAWER_2: begin
                    if (fill_ready) state <= graphics_pkg::STATE_SYMBOL_ITER_START;
                end
                graphics_pkg::STATE_SYMBOL_ITER_START: begin
                    sym_x <= '0;
                    if (symbol_valid) state <= graphics_pkg::STATE_DRAW_FIRST_SYMBOL_1;
                end
                graphics_pkg::STATE_DRAW_FIRST_SYMBOL_1: begin
                    sym_start <= 1'b1;
                    state     <= graphics_pkg::STATE_DRAW_FIRST_SYMBOL_2;
                end
                graphics_pkg::STATE_DRAW_FIRST_SYMBOL_2: begin
                    state <= graphics_pkg::STATE_DRAW_FIRST_SYMBOL_3;
                end
                graphics_pkg::STATE_SYMBOL_ITER_NEXT: begin
                    if (symbol_valid) begin
                        sym_start <= 1'b1;
                        state     <= graphics_pkg::STATE_WAIT_SYMBOL_DRAWER_1;
                    end
                end
                graphics_pkg::STATE_WAIT_SYMBOL_DRAWER_1: begin
                    state <= graphics_pkg::STATE_WAIT_SYMBOL_DRAWER_2;
                end
                graphics_pkg::STATE_DRAW_FIRST_SYMBOL_3,
                graphics_pkg::STATE_WAIT_SYMBOL_DRAWER_2: begin
                    if (sym_done) begin
                        sym_x <= sym_x + `GFX_X_W'(`GFX_CELL_STEP);
                        // symbol 0 ends the line.
                        state <= (symbol == '0) ? graphics_pkg::STATE_LOGIC_START
                                                : graphics_pkg::STATE_SYMBOL_ITER_NEXT;
                    end
                end
                graphics_pkg::STATE_LOGIC_START: begin
                    logic_start <= 1'b1;
                    state       <= graphics_pkg::STATE_WAIT_LOGIC_1;
                end
                graphics_pkg::STATE_WAIT_LOGIC_1: begin
                    state <= graphics_pkg::STATE_WAIT_LOGIC_2;
                end
                graphics_pkg::STATE_WAIT_LOGIC_2: begin
                    if (logic_ready) state <= graphics_pkg::STATE_WAIT_SWAP;
                end
                default: state <= graphics_pkg::STATE_WAIT_SWAP;
            endcase
        end
    end

    // only one drawer owns the pixel port.
    one_drawer_start: assert property (@(posedge clk) disable iff (!rst_n)
        !(fill_start && sym_start));

endmodule

`default_nettype wire

//--- verilog/graphics_pkg.sv
`default_nettype none

`include "graphics_settings.svh"

package graphics_pkg;

    typedef struct packed {
        logic [`GFX_X_W-1:0] x;
        logic [`GFX_Y_W-1:0] y;
        logic [7:0]          color;
    } pix_wr_t;

    typedef struct packed {
        logic [7:0] fg;
        logic [7:0] bg;
    } color_pair_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [5:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef logic [`GFX_SYMBOL_WIDTH-1:0] symbol_t;

    typedef symbol_t [`GFX_TEXT_DEPTH-1:0] text_buf_t;

    typedef enum logic [3:0] {
        STATE_WAIT_SWAP,
        STATE_FILL_DRAWER_START,
        STATE_WAIT_FILL_DRAWER_1,
        STATE_WAIT_FILL_DRAWER_2,
        STATE_SYMBOL_ITER_START,
        STATE_DRAW_FIRST_SYMBOL_1,
        STATE_DRAW_FIRST_SYMBOL_2,
        STATE_DRAW_FIRST_SYMBOL_3,
        STATE_SYMBOL_ITER_NEXT,
        STATE_WAIT_SYMBOL_DRAWER_1,
        STATE_WAIT_SYMBOL_DRAWER_2,
        STATE_LOGIC_START,
        STATE_WAIT_LOGIC_1,
        STATE_WAIT_LOGIC_2
    } gfx_state_e;

endpackage

`default_nettype wire

//--- verilog/graphics_settings.svh
`ifndef GRAPHICS_SETTINGS_SVH
`define GRAPHICS_SETTINGS_SVH

// screen geometry.
`define GFX_HOR_PIXELS    64
`define GFX_VER_PIXELS    16
`define GFX_X_W           6
`define GFX_Y_W           4

// symbol code and glyph cell.
`define GFX_SYMBOL_WIDTH  7
`define GFX_GLYPH_W       5
`define GFX_GLYPH_H       7
`define GFX_CELL_STEP     15
`define GFX_BASELINE_OFS  10 // origin row is height minus this.

`define GFX_TEXT_DEPTH    4

// clocks between swap ticks.
`define GFX_FRAME_CYCLES  4096

`endif

//--- verilog/graphics_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "graphics_settings.svh"

module graphics_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  graphics_pkg::apb_req_t apb_req,
    output graphics_pkg::apb_rsp_t apb_rsp,
    output graphics_pkg::pix_wr_t  pix,
    output logic                   pix_valid,
    input  logic                   pix_ready
);

    graphics_pkg::color_pair_t colors;
    graphics_pkg::text_buf_t   text;
    graphics_pkg::symbol_t     symbol;
    graphics_pkg::pix_wr_t     fill_pix;
    graphics_pkg::pix_wr_t     sym_pix;
    logic                      enable;
    logic                      swap;
    logic                      logic_start;
    logic                      logic_ready;
    logic                      iter_start;
    logic                      iter_en;
    logic                      symbol_valid;
    logic                      fill_start;
    logic                      fill_ready;
    logic                      fill_valid;
    logic                      fill_pix_ready;
    logic                      sym_start;
    logic                      sym_ready;
    logic                      sym_valid;
    logic                      sym_pix_ready;
    logic [`GFX_X_W-1:0]       sym_x;

    frame_timer u_frame_timer (
        .clk    (clk),
        .rst_n  (rst_n),
        .enable (enable),
        .swap   (swap)
    );

    gfx_apb_regs u_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .logic_start (logic_start),
        .frame_done  (logic_ready), // counted when the FSM takes it.
        .enable      (enable),
        .colors      (colors),
        .text        (text),
        .logic_ready (logic_ready)
    );

    symbol_iter u_symbol_iter (
        .clk          (clk),
        .rst_n        (rst_n),
        .text         (text),
        .iter_start   (iter_start),
        .iter_en      (iter_en),
        .symbol       (symbol),
        .symbol_valid (symbol_valid)
    );

    graphics_fsm u_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .swap         (swap),
        .symbol       (symbol),
        .symbol_valid (symbol_valid),
        .logic_ready  (logic_ready),
        .fill_ready   (fill_ready),
        .sym_ready    (sym_ready),
        .iter_start   (iter_start),
        .iter_en      (iter_en),
        .logic_start  (logic_start),
        .fill_start   (fill_start),
        .sym_start    (sym_start),
        .sym_x        (sym_x)
    );

    fill_drawer u_fill (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (fill_start),
        .bg        (colors.bg),
        .pix       (fill_pix),
        .pix_valid (fill_valid),
        .pix_ready (fill_pix_ready),
        .ready     (fill_ready)
    );

    symbol_drawer u_symbol (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (sym_start),
        .symbol    (symbol),
        .x0        (sym_x),
        .fg        (colors.fg),
        .pix_ready (sym_pix_ready),
        .pix       (sym_pix),
        .pix_valid (sym_valid),
        .ready     (sym_ready)
    );

    pixel_port u_pixel_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .fill_pix   (fill_pix),
        .fill_valid (fill_valid),
        .fill_ready (fill_pix_ready),
        .sym_pix    (sym_pix),
        .sym_valid  (sym_valid),
        .sym_ready  (sym_pix_ready),
        .pix        (pix),
        .pix_valid  (pix_valid),
        .pix_ready  (pix_ready)
    );

endmodule

`default_nettype wire

//--- verilog/pixel_port.sv
`timescale 1ns/100ps
`default_nettype none

module pixel_port (
    input  logic                  clk,
    input  logic                  rst_n,
    input  graphics_pkg::pix_wr_t fill_pix,
    input  logic                  fill_valid,
    output logic                  fill_ready,
    input  graphics_pkg::pix_wr_t sym_pix,
    input  logic                  sym_valid,
    output logic                  sym_ready,
    output graphics_pkg::pix_wr_t pix,
    output logic                  pix_valid,
    input  logic                  pix_ready
);

    logic load;

    assign load       = !pix_valid || pix_ready; // empty or draining.
    assign fill_ready = load;
    assign sym_ready  = load && !fill_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pix_valid <= 1'b0;
        end else if (load) begin
            pix_valid <= fill_valid || sym_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load && (fill_valid || sym_valid)) begin
            pix <= fill_valid ? fill_pix : sym_pix;
        end
    end

    // no pixel changes under back-pressure.
    pix_hold: assert property (@(posedge clk) disable iff (!rst_n)
        pix_valid && !pix_ready |=> pix_valid && $stable(pix));

endmodule

`default_nettype wire

//--- verilog/symbol_drawer.sv
`timescale 1ns/100ps
`default_nettype none

`include "graphics_settings.svh"

module symbol_drawer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  graphics_pkg::symbol_t symbol,
    input  logic [`GFX_X_W-1:0]   x0,
    input  logic [7:0]            fg,
    input  logic                  pix_ready,
    output graphics_pkg::pix_wr_t pix,
    output logic                  pix_valid,
    output logic                  ready
);

    localparam int NPOS  = `GFX_GLYPH_W * `GFX_GLYPH_H;
    localparam int POS_W = $clog2(NPOS);
    localparam logic [`GFX_Y_W-1:0] Y0 = `GFX_Y_W'(`GFX_VER_PIXELS - `GFX_BASELINE_OFS);

    logic [NPOS-1:0]     mask;
    logic [NPOS-1:0]     remaining; // set pixels still to emit.
    logic [POS_W-1:0]    pos;
    logic [`GFX_X_W-1:0] x_org;

    // bit rule, position r*W + c takes bit (c + r) mod 7.
    always_comb begin
        mask = '0;
        for (int r = 0; r < `GFX_GLYPH_H; r++) begin
            for (int c = 0; c < `GFX_GLYPH_W; c++) begin
                mask[r * `GFX_GLYPH_W + c] = symbol[(c + r) % `GFX_SYMBOL_WIDTH];
            end
        end
    end

    // lowest pending position, so unset pixels cost no cycle.
    always_comb begin
        pos = '0;
        for (int p = NPOS - 1; p >= 0; p--) begin
            if (remaining[p]) pos = POS_W'(p);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            remaining <= '0;
        end else if (start) begin
            remaining <= mask;
        end else if (pix_valid && pix_ready) begin
            remaining <= remaining & (remaining - 1'b1); // drop lowest set bit.
        end
    end

    always_ff @(posedge clk) begin
        if (start) x_org <= x0;
    end

    assign pix.x     = x_org + `GFX_X_W'(pos % `GFX_GLYPH_W);
    assign pix.y     = Y0 + `GFX_Y_W'(pos / `GFX_GLYPH_W);
    assign pix.color = fg;
    assign pix_valid = |remaining;
    assign ready     = ~|remaining;

endmodule

`default_nettype wire

//--- verilog/symbol_iter.sv
`timescale 1ns/100ps
`default_nettype none

`include "graphics_settings.svh"

module symbol_iter (
    input  logic                    clk,
    input  logic                    rst_n,
    input  graphics_pkg::text_buf_t text,
    input  logic                    iter_start,
    input  logic                    iter_en,
    output graphics_pkg::symbol_t   symbol,
    output logic                    symbol_valid
);

    localparam int IDX_W = $clog2(`GFX_TEXT_DEPTH + 1);
    localparam logic [IDX_W-1:0] LAST = IDX_W'(`GFX_TEXT_DEPTH);

    logic [IDX_W-1:0] idx;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            idx          <= '0;
            symbol_valid <= 1'b0;
        end else if (iter_start) begin
            idx          <= '0;
            symbol_valid <= 1'b0;
        end else if (iter_en) begin
            if (idx != LAST) idx <= idx + 1'b1; // saturates past the end.
            symbol_valid <= 1'b0;
        end else begin
            symbol_valid <= 1'b1;
        end
    end

    // terminator once the buffer is exhausted.
    assign symbol = (idx < LAST) ? text[idx[IDX_W-2:0]] : '0;

endmodule

`default_nettype wire
